// ==== build.f ====
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/char_motion.sv
verilog/terrain_layer.sv
verilog/sprite_layer.sv
verilog/pixel_mixer.sv
verilog/game_top.sv
sim/game_assert.sv
sim/game_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= game_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --assert
PASS_MSG ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/game_tb.sv ====
module game_tb;
    import game_pkg::*;

    // a tiny raster keeps one frame at 640 clocks.
    localparam int h_active = 24, h_front = 2, h_sync = 3, h_back = 3;
    localparam int v_active = 16, v_front = 1, v_sync = 2, v_back = 1;
    localparam int ground_y = 12, block_x = 8, block_y = 10, block_w = 6, block_h = 3;
    localparam int char_w = 4, char_h = 4, char_step = 3, jump_speed = 3;
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles = h_total * v_total;
    localparam int total_frames = 92;

    logic clk, rst;
    logic stepleft, stepright, stepjump;
    logic hs, vs, on_ground;
    rgb_t rgb;
    logic [coord_w-1:0] char_x, char_y;

    integer seed;
    int cur_h, cur_v;
    int mx, my, mvel;
    int errors, passed_tests, failed_tests;
    string test_name;
    logic [2:0] check_mask;
    logic exp_hs [0:2];
    logic exp_vs [0:2];
    rgb_t exp_rgb [0:2];

    game_top #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
        .ground_y(ground_y), .block_x(block_x), .block_y(block_y), .block_w(block_w),
        .block_h(block_h), .char_w(char_w), .char_h(char_h), .char_step(char_step),
        .jump_speed(jump_speed)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((total_frames + 4) * frame_cycles * 10);
        $display("timeout: the run did not finish within %0d frames", total_frames + 4);
        $display("Some tests failed");
        $finish;
    end

    function automatic rgb_t pixel_color(input int h, input int v);
        if (h >= h_active || v >= v_active)
            return '0;
        if (h >= mx && h < mx + char_w && v >= my && v < my + char_h)
            return char_color;
        if (h >= block_x && h < block_x + block_w &&
            v >= block_y && v < block_y + block_h)
            return block_color;
        if (v >= ground_y)
            return ground_color;
        return bg_color;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    // the character moves once per frame, sideways first, then jumps or falls and lands.
    task automatic apply_motion();
        int nx;
        logic grounded;
        grounded = my + char_h == ground_y;
        nx = mx;
        if (stepleft && !stepright)
            nx = mx - char_step;
        else if (stepright && !stepleft)
            nx = mx + char_step;
        mx = (nx < 0) ? 0 : (nx > h_active - char_w) ? h_active - char_w : nx;
        if (grounded && stepjump)
            mvel = -jump_speed;
        else if (!grounded)
            mvel = mvel + 1;
        else
            mvel = 0;
        my = my + mvel;
        if (my + char_h > ground_y) begin
            my = ground_y - char_h;
            mvel = 0;
        end
    endtask

    // the outputs lag the counters by two clocks, so three expected values are kept.
    task automatic push_expected();
        for (int i = 2; i > 0; i--) begin
            exp_hs[i] = exp_hs[i-1];
            exp_vs[i] = exp_vs[i-1];
            exp_rgb[i] = exp_rgb[i-1];
        end
        exp_hs[0] = !(cur_h >= h_active + h_front && cur_h < h_active + h_front + h_sync);
        exp_vs[0] = !(cur_v >= v_active + v_front && cur_v < v_active + v_front + v_sync);
        exp_rgb[0] = pixel_color(cur_h, cur_v);
    endtask

    task automatic step_cycle(input int mode, input int frame);
        int r;
        logic lean, back;
        @(posedge clk);
        #1;
        if (cur_h == 0 && cur_v == v_active)
            apply_motion();
        if (cur_h == h_total - 1) begin
            cur_h = 0;
            cur_v = (cur_v == v_total - 1) ? 0 : cur_v + 1;
        end else begin
            cur_h++;
        end
        push_expected();
        if (check_mask[0] && hs !== exp_hs[2])
            report_mismatch("hs", int'(exp_hs[2]), int'(hs));
        if (check_mask[0] && vs !== exp_vs[2])
            report_mismatch("vs", int'(exp_vs[2]), int'(vs));
        if (check_mask[1] && rgb !== exp_rgb[2])
            report_mismatch("rgb", int'(exp_rgb[2]), int'(rgb));
        if (check_mask[2] && int'(char_x) != mx)
            report_mismatch("char_x", mx, int'(char_x));
        if (check_mask[2] && int'(char_y) != my)
            report_mismatch("char_y", my, int'(char_y));
        if (check_mask[2] && on_ground !== (my + char_h == ground_y))
            report_mismatch("on_ground", int'(my + char_h == ground_y), int'(on_ground));
        // inputs only change in the middle of the active lines.
        if (cur_h == 0 && cur_v == v_active / 2) begin
            r = $random(seed);
            lean = r[1:0] != 2'd0;
            back = r[1:0] == 2'd0 || r[1:0] == 2'd3;
            stepleft = 1'b0;
            stepright = 1'b0;
            stepjump = 1'b0;
            case (mode)
                1: begin
                    // the walk leans right for 20 frames and then left.
                    // eight straight steps close each half so both edges are hit.
                    if (frame % 20 >= 12) begin
                        stepright = frame < 20;
                        stepleft = frame >= 20;
                    end else begin
                        stepright = (frame < 20) ? lean : back;
                        stepleft = (frame < 20) ? back : lean;
                    end
                end
                2: stepjump = frame == 0;
                3: begin
                    stepleft = r[0];
                    stepright = r[1];
                    stepjump = r[2];
                end
                default: stepjump = 1'b0;
            endcase
        end
    endtask

    // mask bit 0 checks the syncs, bit 1 the pixels and bit 2 the character state.
    task automatic run_test(input string name, input int frames, input int mode,
                            input logic [2:0] mask);
        test_name = name;
        check_mask = mask;
        for (int c = 0; c < frames * frame_cycles; c++)
            step_cycle(mode, c / frame_cycles);
        if (errors == 0) begin
            passed_tests++;
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    initial begin
        seed = 40;
        rst = 1'b1;
        stepleft = 1'b0;
        stepright = 1'b0;
        stepjump = 1'b0;
        errors = 0;
        passed_tests = 0;
        failed_tests = 0;
        cur_h = 0;
        cur_v = 0;
        mx = 0;
        my = ground_y - char_h;
        mvel = 0;
        // until the pipeline fills, the mixer shows its idle levels.
        for (int i = 0; i < 3; i++) begin
            exp_hs[i] = 1'b1;
            exp_vs[i] = 1'b1;
            exp_rgb[i] = '0;
        end
        push_expected();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_name = "sync_timing";
        if (hs !== 1'b1)
            report_mismatch("hs after reset", 1, int'(hs));
        if (vs !== 1'b1)
            report_mismatch("vs after reset", 1, int'(vs));
        run_test("sync_timing", 1, 0, 3'b001);
        run_test("static_picture", 1, 0, 3'b010);
        run_test("walk_clamp", 40, 1, 3'b110);
        run_test("jump_arc", 10, 2, 3'b100);
        run_test("random_play", 40, 3, 3'b111);
        $display("summary: %0d run, %0d passed, %0d failed", passed_tests + failed_tests,
                 passed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/game_assert.sv ====
module game_assert #(
    parameter bit check_motion = 1'b0,
    parameter int x_max = 4095,
    parameter int y_rest = 4095
) (
    input logic clk,
    input logic rst,
    input logic blank_d,
    input game_pkg::rgb_t rgb,
    input logic [game_pkg::coord_w-1:0] char_x,
    input logic [game_pkg::coord_w-1:0] char_y
);

    // the motion unit carries the position checks and the mixer the blanking check.
    generate
        if (check_motion) begin : g_motion
            // the top row of the character never lets its bottom drop below ground_y.
            above_ground: assert property (@(posedge clk) disable iff (rst)
                int'(char_y) <= y_rest)
                else $error("character bottom passed the ground");

            x_in_range: assert property (@(posedge clk) disable iff (rst)
                int'(char_x) <= x_max)
                else $error("character x left the screen");
        end else begin : g_mixer
            // a blanked pixel leaves the mixer as black on the next clock.
            blank_black: assert property (@(posedge clk) disable iff (rst)
                blank_d |=> rgb == '0)
                else $error("rgb is not zero after a blanked pixel");
        end
    endgenerate

endmodule

bind pixel_mixer game_assert u_mixer_assert (
    .clk,
    .rst,
    .blank_d,
    .rgb,
    .char_x('0),
    .char_y('0)
);

bind char_motion game_assert #(
    .check_motion(1'b1),
    .x_max(x_max),
    .y_rest(y_rest)
) u_motion_assert (
    .clk,
    .rst,
    .blank_d(1'b0),
    .rgb('0),
    .char_x,
    .char_y
);

// ==== verilog/game_top.sv ====
module game_top #(
    parameter int h_active = 640,
    parameter int h_front = 16,
    parameter int h_sync = 96,
    parameter int h_back = 48,
    parameter int v_active = 480,
    parameter int v_front = 10,
    parameter int v_sync = 2,
    parameter int v_back = 33,
    parameter int ground_y = 400,
    parameter int block_x = 260,
    parameter int block_y = 300,
    parameter int block_w = 120,
    parameter int block_h = 24,
    parameter int char_w = 32,
    parameter int char_h = 48,
    parameter int char_step = 4,
    parameter int jump_speed = 12
) (
    input  logic clk,
    input  logic rst,
    input  logic stepleft,
    input  logic stepright,
    input  logic stepjump,
    output logic hs,
    output logic vs,
    output logic on_ground,
    output game_pkg::rgb_t rgb,
    output logic [game_pkg::coord_w-1:0] char_x,
    output logic [game_pkg::coord_w-1:0] char_y
);
    import game_pkg::*;

    logic [coord_w-1:0] hcount;
    logic [coord_w-1:0] vcount;
    logic hsync;
    logic vsync;
    logic blank;
    logic frame_tick;
    logic terr_hit;
    logic spr_hit;
    rgb_t terr_rgb;
    rgb_t spr_rgb;

    vga_timing #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back)
    ) u_vga_timing (
        .clk,
        .rst,
        .hcount,
        .vcount,
        .hsync,
        .vsync,
        .blank,
        .frame_tick
    );

    char_motion #(
        .h_active(h_active),
        .ground_y(ground_y),
        .char_w(char_w),
        .char_h(char_h),
        .char_step(char_step),
        .jump_speed(jump_speed)
    ) u_char_motion (
        .clk,
        .rst,
        .frame_tick,
        .stepleft,
        .stepright,
        .stepjump,
        .char_x,
        .char_y,
        .on_ground
    );

    terrain_layer #(
        .ground_y(ground_y),
        .block_x(block_x),
        .block_y(block_y),
        .block_w(block_w),
        .block_h(block_h)
    ) u_terrain_layer (
        .clk,
        .rst,
        .hcount,
        .vcount,
        .terr_hit,
        .terr_rgb
    );

    sprite_layer #(
        .char_w(char_w),
        .char_h(char_h)
    ) u_sprite_layer (
        .clk,
        .rst,
        .hcount,
        .vcount,
        .char_x,
        .char_y,
        .spr_hit,
        .spr_rgb
    );

    pixel_mixer u_pixel_mixer (
        .clk,
        .rst,
        .hsync,
        .vsync,
        .blank,
        .terr_hit,
        .spr_hit,
        .terr_rgb,
        .spr_rgb,
        .hs,
        .vs,
        .rgb
    );

endmodule

// ==== verilog/pixel_mixer.sv ====
module pixel_mixer (
    input  logic clk,
    input  logic rst,
    input  logic hsync,
    input  logic vsync,
    input  logic blank,
    input  logic terr_hit,
    input  logic spr_hit,
    input  game_pkg::rgb_t terr_rgb,
    input  game_pkg::rgb_t spr_rgb,
    output logic hs,
    output logic vs,
    output game_pkg::rgb_t rgb
);
    import game_pkg::*;

    logic hsync_d;
    logic vsync_d;
    logic blank_d;
    rgb_t pixel;

    // blanking first, then the sprite above the terrain above the sky.
    always_comb begin
        if (blank_d) begin
            pixel = '0;
        end else if (spr_hit) begin
            pixel = spr_rgb;
        end else if (terr_hit) begin
            pixel = terr_rgb;
        end else begin
            pixel = bg_color;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            blank_d <= 1'b1;
            hs <= 1'b1;
            vs <= 1'b1;
            rgb <= '0;
        end else begin
            hsync_d <= hsync;
            vsync_d <= vsync;
            blank_d <= blank;
            hs <= hsync_d;
            vs <= vsync_d;
            rgb <= pixel;
        end
    end

endmodule

// ==== verilog/sprite_layer.sv ====
module sprite_layer #(
    parameter int char_w = 32,
    parameter int char_h = 48
) (
    input  logic clk,
    input  logic rst,
    input  logic [game_pkg::coord_w-1:0] hcount,
    input  logic [game_pkg::coord_w-1:0] vcount,
    input  logic [game_pkg::coord_w-1:0] char_x,
    input  logic [game_pkg::coord_w-1:0] char_y,
    output logic spr_hit,
    output game_pkg::rgb_t spr_rgb
);
    import game_pkg::*;

    // one extra bit so the far edges cannot wrap near the counter limit.
    logic [coord_w:0] right_edge;
    logic [coord_w:0] bottom_edge;
    logic in_x;
    logic in_y;

    assign right_edge = {1'b0, char_x} + (coord_w + 1)'(char_w);
    assign bottom_edge = {1'b0, char_y} + (coord_w + 1)'(char_h);

    assign in_x = (hcount >= char_x) && ({1'b0, hcount} < right_edge);
    assign in_y = (vcount >= char_y) && ({1'b0, vcount} < bottom_edge);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            spr_hit <= 1'b0;
        end else begin
            spr_hit <= in_x && in_y;
        end
    end

    always_ff @(posedge clk) begin
        spr_rgb <= char_color;
    end

endmodule

// ==== verilog/terrain_layer.sv ====
module terrain_layer #(
    parameter int ground_y = 400,
    parameter int block_x = 260,
    parameter int block_y = 300,
    parameter int block_w = 120,
    parameter int block_h = 24
) (
    input  logic clk,
    input  logic rst,
    input  logic [game_pkg::coord_w-1:0] hcount,
    input  logic [game_pkg::coord_w-1:0] vcount,
    output logic terr_hit,
    output game_pkg::rgb_t terr_rgb
);
    import game_pkg::*;

    localparam logic [coord_w-1:0] gnd_top = coord_w'(ground_y);
    localparam logic [coord_w-1:0] blk_left = coord_w'(block_x);
    localparam logic [coord_w-1:0] blk_right = coord_w'(block_x + block_w);
    localparam logic [coord_w-1:0] blk_top = coord_w'(block_y);
    localparam logic [coord_w-1:0] blk_bottom = coord_w'(block_y + block_h);

    logic in_ground;
    logic in_block;

    assign in_ground = vcount >= gnd_top;

    assign in_block = (hcount >= blk_left) && (hcount < blk_right) &&
                      (vcount >= blk_top) && (vcount < blk_bottom);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            terr_hit <= 1'b0;
        end else begin
            terr_hit <= in_ground || in_block;
        end
    end

    // the colour only matters while terr_hit is set.
    always_ff @(posedge clk) begin
        if (in_block) begin
            terr_rgb <= block_color;
        end else begin
            terr_rgb <= ground_color;
        end
    end

endmodule

// ==== verilog/char_motion.sv ====
module char_motion #(
    parameter int h_active = 640,
    parameter int ground_y = 400,
    parameter int char_w = 32,
    parameter int char_h = 48,
    parameter int char_step = 4,
    parameter int jump_speed = 12
) (
    input  logic clk,
    input  logic rst,
    input  logic frame_tick,
    input  logic stepleft,
    input  logic stepright,
    input  logic stepjump,
    output logic [game_pkg::coord_w-1:0] char_x,
    output logic [game_pkg::coord_w-1:0] char_y,
    output logic on_ground
);
    import game_pkg::*;

    localparam int x_max = h_active - char_w;
    localparam int y_rest = ground_y - char_h;

    logic signed [coord_w-1:0] vel;
    logic signed [coord_w-1:0] vel_next;
    logic [coord_w-1:0] x_next;
    logic [coord_w-1:0] y_next;
    int x_sum;
    int y_sum;

    assign on_ground = (int'(char_y) + char_h) == ground_y;

    always_comb begin
        x_sum = int'(char_x);
        if (stepleft && !stepright) begin
            x_sum = int'(char_x) - char_step;
        end else if (stepright && !stepleft) begin
            x_sum = int'(char_x) + char_step;
        end
        if (x_sum < 0) begin
            x_next = '0;
        end else if (x_sum > x_max) begin
            x_next = coord_w'(x_max);
        end else begin
            x_next = coord_w'(x_sum);
        end
    end

    // a jump only starts from the ground; in the air gravity adds one per frame.
    always_comb begin
        if (on_ground && stepjump) begin
            vel_next = -coord_w'(jump_speed);
        end else if (!on_ground) begin
            vel_next = vel + 1'b1;
        end else begin
            vel_next = '0;
        end
        y_sum = int'(char_y) + int'(vel_next);
        y_next = coord_w'(y_sum);
        if (y_sum > y_rest) begin
            y_next = coord_w'(y_rest);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            char_x <= '0;
            char_y <= coord_w'(y_rest);
            vel <= '0;
        end else if (frame_tick) begin
            char_x <= x_next;
            char_y <= y_next;
            // landing stops the fall.
            vel <= (y_sum > y_rest) ? '0 : vel_next;
        end
    end

endmodule

// ==== verilog/vga_timing.sv ====
module vga_timing #(
    parameter int h_active = 640,
    parameter int h_front = 16,
    parameter int h_sync = 96,
    parameter int h_back = 48,
    parameter int v_active = 480,
    parameter int v_front = 10,
    parameter int v_sync = 2,
    parameter int v_back = 33
) (
    input  logic clk,
    input  logic rst,
    output logic [game_pkg::coord_w-1:0] hcount,
    output logic [game_pkg::coord_w-1:0] vcount,
    output logic hsync,
    output logic vsync,
    output logic blank,
    output logic frame_tick
);
    import game_pkg::*;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    localparam logic [coord_w-1:0] h_last = coord_w'(h_total - 1);
    localparam logic [coord_w-1:0] v_last = coord_w'(v_total - 1);
    localparam logic [coord_w-1:0] hs_start = coord_w'(h_active + h_front);
    localparam logic [coord_w-1:0] hs_end = coord_w'(h_active + h_front + h_sync);
    localparam logic [coord_w-1:0] vs_start = coord_w'(v_active + v_front);
    localparam logic [coord_w-1:0] vs_end = coord_w'(v_active + v_front + v_sync);
    localparam logic [coord_w-1:0] h_vis = coord_w'(h_active);
    localparam logic [coord_w-1:0] v_vis = coord_w'(v_active);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            hcount <= '0;
            if (vcount == v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // both syncs are active low inside their intervals.
    assign hsync = !((hcount >= hs_start) && (hcount < hs_end));
    assign vsync = !((vcount >= vs_start) && (vcount < vs_end));

    assign blank = (hcount >= h_vis) || (vcount >= v_vis);

    // first pixel of the first blanked line, so motion updates land in vblank.
    assign frame_tick = (hcount == '0) && (vcount == v_vis);

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

    // every pixel coordinate and raster counter uses this width.
    localparam int coord_w = 12;

    // one colour channel; the rgb bus carries red, green and blue in that order.
    localparam int color_w = 4;
    localparam int rgb_w = 3 * color_w;

    typedef logic [rgb_w-1:0] rgb_t;

    // sky behind everything else.
    localparam rgb_t bg_color = 12'h3_6_c;

    // brown band along the bottom of the screen.
    localparam rgb_t ground_color = 12'h7_4_1;

    // grey floating block.
    localparam rgb_t block_color = 12'h9_9_9;

    // the player character, kept bright so it stands out on both layers.
    localparam rgb_t char_color = 12'hf_a_0;

endpackage
